// ==== hw/iterCtrl.sv ====
module iterCtrl #(
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  rootDivPkg::opKind_t op,
  input  logic lastStep,
  input  logic accept,
  output rootDivPkg::unitState_t state,
  output rootDivPkg::stepCnt_t loadSteps,
  output logic stepEn,
  output logic done
);

  rootDivPkg::unitState_t nextState;

  always_comb begin
    nextState = state;
    case (state)
      rootDivPkg::ST_IDLE: if (start) nextState = rootDivPkg::ST_RUN;
      rootDivPkg::ST_RUN:  if (lastStep) nextState = rootDivPkg::ST_HOLD;
      rootDivPkg::ST_HOLD: if (accept) nextState = rootDivPkg::ST_IDLE;
      default:             nextState = rootDivPkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rootDivPkg::ST_IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign loadSteps = rootDivPkg::stepsFor(op, DATA_W);
  assign stepEn = (state == rootDivPkg::ST_RUN);   // one datapath step per run cycle
  assign done = (state == rootDivPkg::ST_HOLD);

  // the queue only issues to an engine that reported free
  startWhenIdle: assert property (@(posedge clk) disable iff (rst)
    start |-> state == rootDivPkg::ST_IDLE);

endmodule

// ==== hw/opQueue.sv ====
module opQueue #(
  parameter int DATA_W = 32,
  parameter int NUM_UNITS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  output logic inReady,
  input  rootDivPkg::opKind_t inOp,
  input  logic [DATA_W-1:0] inA,
  input  logic [DATA_W-1:0] inB,
  input  rootDivPkg::regNo_t inRegNo,
  input  rootDivPkg::instrId_t inId,
  input  logic [NUM_UNITS-1:0] unitFree,
  output logic [NUM_UNITS-1:0] issueStart,
  output rootDivPkg::opKind_t issueOp,
  output logic [DATA_W-1:0] issueA,
  output logic [DATA_W-1:0] issueB,
  output rootDivPkg::regNo_t issueRegNo,
  output rootDivPkg::instrId_t issueId
);

  // slot 0 is always the head
  rootDivPkg::opKind_t opQ [2];
  logic [DATA_W-1:0] aQ [2];
  logic [DATA_W-1:0] bQ [2];
  rootDivPkg::regNo_t regQ [2];
  rootDivPkg::instrId_t idQ [2];

  logic [1:0] count;
  logic headValid;
  logic doPush;
  logic doPop;
  logic wrIdx;
  logic [NUM_UNITS-1:0] pick;

  assign inReady = (count != 2'd2);
  assign headValid = (count != 2'd0);
  assign doPush = inValid && inReady;
  assign doPop = headValid && (|unitFree);

  // lowest set bit of the free mask
  assign pick = unitFree & (-unitFree);
  assign issueStart = headValid ? pick : '0;

  assign issueOp = opQ[0];
  assign issueA = aQ[0];
  assign issueB = bQ[0];
  assign issueRegNo = regQ[0];
  assign issueId = idQ[0];

  // where the new entry lands after any pop this cycle
  assign wrIdx = (count == 2'd2) || (count == 2'd1 && !doPop);

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= 2'd0;
    end else begin
      count <= count + {1'b0, doPush} - {1'b0, doPop};
    end
  end

  always_ff @(posedge clk) begin
    if (doPop) begin
      opQ[0] <= opQ[1];
      aQ[0] <= aQ[1];
      bQ[0] <= bQ[1];
      regQ[0] <= regQ[1];
      idQ[0] <= idQ[1];
    end
    if (doPush) begin  // comes after the shift so it wins on slot 0
      opQ[wrIdx] <= inOp;
      aQ[wrIdx] <= inA;
      bQ[wrIdx] <= inB;
      regQ[wrIdx] <= inRegNo;
      idQ[wrIdx] <= inId;
    end
  end

  // each issue claims its engine, so no engine is started twice
  issueTaken: assert property (@(posedge clk) disable iff (rst)
    issueStart != '0 |=> (unitFree & $past(issueStart)) == '0);

endmodule

// ==== hw/radix2Core.sv ====
module radix2Core #(
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  rootDivPkg::opKind_t op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  logic stepEn,
  output logic [DATA_W-1:0] result,
  output logic [DATA_W-1:0] rem
);

  rootDivPkg::opKind_t opReg;
  logic [DATA_W-1:0] src;        // dividend or radicand bits not yet consumed
  logic [DATA_W-1:0] divisor;
  logic [DATA_W-1:0] acc;        // quotient or root, grows from the lsb
  logic [DATA_W-1:0] remReg;     // partial remainder

  logic [DATA_W:0] partial;
  logic [DATA_W:0] subtrahend;
  logic [DATA_W+1:0] diff;
  logic fits;

  // trial subtraction for the current step
  always_comb begin
    if (opReg == rootDivPkg::OP_ROOT) begin
      // remainder stays below 2*root, so its msb is free for root
      partial = {remReg[DATA_W-2:0], src[DATA_W-1 -: 2]};
      subtrahend = {acc[DATA_W-2:0], 2'b01};   // 4*root + 1
    end else begin
      partial = {remReg, src[DATA_W-1]};
      subtrahend = {1'b0, divisor};
    end
    diff = {1'b0, partial} - {1'b0, subtrahend};
    fits = ~diff[DATA_W+1];   // no borrow
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      opReg <= rootDivPkg::OP_DIV;
    end else if (start) begin
      opReg <= op;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      src <= a;
      divisor <= b;
      acc <= '0;
      remReg <= '0;
    end else if (stepEn) begin
      if (opReg == rootDivPkg::OP_ROOT) begin
        src <= src << 2;
      end else begin
        src <= src << 1;
      end
      acc <= {acc[DATA_W-2:0], fits};
      // keep the difference or restore the shifted remainder.
      // with a zero divisor every trial fits, giving all ones and rem = a
      remReg <= fits ? diff[DATA_W-1:0] : partial[DATA_W-1:0];
    end
  end

  assign result = acc;
  assign rem = remReg;

endmodule

// ==== hw/resultArbiter.sv ====
module resultArbiter #(
  parameter int DATA_W = 32,
  parameter int NUM_UNITS = 4
) (
  input  logic clk,
  input  logic rst,
  unitResultIf.sink res [NUM_UNITS],
  output logic outValid,
  input  logic outReady,
  output logic [DATA_W-1:0] outResult,
  output logic [DATA_W-1:0] outRem,
  output rootDivPkg::regNo_t outRegNo,
  output rootDivPkg::instrId_t outId
);

  logic [NUM_UNITS-1:0] doneVec;
  logic [NUM_UNITS-1:0] firstDone;
  logic [NUM_UNITS-1:0] grant;
  logic [NUM_UNITS-1:0] lockGrant;
  logic locked;
  logic [DATA_W-1:0] resultArr [NUM_UNITS];
  logic [DATA_W-1:0] remArr [NUM_UNITS];
  rootDivPkg::regNo_t regArr [NUM_UNITS];
  rootDivPkg::instrId_t idArr [NUM_UNITS];

  for (genvar i = 0; i < NUM_UNITS; i++) begin : gather
    assign doneVec[i] = res[i].done;
    assign resultArr[i] = res[i].result;
    assign remArr[i] = res[i].rem;
    assign regArr[i] = res[i].regNo;
    assign idArr[i] = res[i].instId;
    assign res[i].accept = grant[i] & outReady;
  end

  assign firstDone = doneVec & (-doneVec);   // lowest-index done engine
  // a stalled grant stays put even if a lower engine finishes meanwhile
  assign grant = locked ? lockGrant : firstDone;
  assign outValid = |doneVec;

  always_comb begin
    outResult = '0;
    outRem = '0;
    outRegNo = '0;
    outId = '0;
    for (int i = 0; i < NUM_UNITS; i++) begin
      if (grant[i]) begin
        outResult = resultArr[i];
        outRem = remArr[i];
        outRegNo = regArr[i];
        outId = idArr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked <= 1'b0;
      lockGrant <= '0;
    end else begin
      locked <= outValid && !outReady;
      lockGrant <= grant;
    end
  end

  outputHeld: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outResult) && $stable(outRem)
      && $stable(outRegNo) && $stable(outId));

endmodule

// ==== hw/rootDivPkg.sv ====
package rootDivPkg;

  // widest operand any configuration may use
  localparam int MAX_DATA_W = 64;

  typedef logic [8:0] regNo_t;     // destination register number
  typedef logic [9:0] instrId_t;   // lets results come back out of order

  // must hold MAX_DATA_W itself
  typedef logic [$clog2(MAX_DATA_W + 1)-1:0] stepCnt_t;

  typedef enum logic {
    OP_DIV  = 1'b0,
    OP_ROOT = 1'b1
  } opKind_t;

  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_HOLD = 2'd2
  } unitState_t;

  // division retires one bit per step, root two bits per step
  function automatic stepCnt_t stepsFor(opKind_t op, int dataW);
    if (op == OP_ROOT) begin
      return stepCnt_t'(dataW / 2);
    end
    return stepCnt_t'(dataW);
  endfunction

endpackage

// ==== hw/rootDivTop.sv ====
module rootDivTop #(
  parameter int DATA_W = 32,
  parameter int NUM_UNITS = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  output logic inReady,
  input  rootDivPkg::opKind_t inOp,
  input  logic [DATA_W-1:0] inA,
  input  logic [DATA_W-1:0] inB,
  input  rootDivPkg::regNo_t inRegNo,
  input  rootDivPkg::instrId_t inId,
  output logic outValid,
  input  logic outReady,
  output logic [DATA_W-1:0] outResult,
  output logic [DATA_W-1:0] outRem,
  output rootDivPkg::regNo_t outRegNo,
  output rootDivPkg::instrId_t outId
);

  logic [NUM_UNITS-1:0] unitFree;
  logic [NUM_UNITS-1:0] issueStart;
  rootDivPkg::opKind_t issueOp;
  logic [DATA_W-1:0] issueA;
  logic [DATA_W-1:0] issueB;
  rootDivPkg::regNo_t issueRegNo;
  rootDivPkg::instrId_t issueId;

  unitResultIf #(.DATA_W(DATA_W)) resBus [NUM_UNITS] ();

  opQueue #(.DATA_W(DATA_W), .NUM_UNITS(NUM_UNITS)) queue0 (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inReady(inReady),
    .inOp(inOp),
    .inA(inA),
    .inB(inB),
    .inRegNo(inRegNo),
    .inId(inId),
    .unitFree(unitFree),
    .issueStart(issueStart),
    .issueOp(issueOp),
    .issueA(issueA),
    .issueB(issueB),
    .issueRegNo(issueRegNo),
    .issueId(issueId)
  );

  // operands and tags are shared, the start bit picks the engine
  for (genvar i = 0; i < NUM_UNITS; i++) begin : unitGen
    rootDivUnit #(.DATA_W(DATA_W)) unit0 (
      .clk(clk),
      .rst(rst),
      .start(issueStart[i]),
      .op(issueOp),
      .a(issueA),
      .b(issueB),
      .regNo(issueRegNo),
      .instId(issueId),
      .free(unitFree[i]),
      .res(resBus[i])
    );
  end

  resultArbiter #(.DATA_W(DATA_W), .NUM_UNITS(NUM_UNITS)) arbiter0 (
    .clk(clk),
    .rst(rst),
    .res(resBus),
    .outValid(outValid),
    .outReady(outReady),
    .outResult(outResult),
    .outRem(outRem),
    .outRegNo(outRegNo),
    .outId(outId)
  );

endmodule

// ==== hw/rootDivUnit.sv ====
module rootDivUnit #(
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  rootDivPkg::opKind_t op,
  input  logic [DATA_W-1:0] a,
  input  logic [DATA_W-1:0] b,
  input  rootDivPkg::regNo_t regNo,
  input  rootDivPkg::instrId_t instId,
  output logic free,
  unitResultIf.source res
);

  rootDivPkg::unitState_t state;
  rootDivPkg::stepCnt_t loadSteps;
  logic stepEn;
  logic lastStep;
  logic done;
  logic [DATA_W-1:0] coreResult;
  logic [DATA_W-1:0] coreRem;
  rootDivPkg::regNo_t regNoReg;
  rootDivPkg::instrId_t idReg;

  iterCtrl #(.DATA_W(DATA_W)) ctrl0 (
    .clk(clk),
    .rst(rst),
    .start(start),
    .op(op),
    .lastStep(lastStep),
    .accept(res.accept),
    .state(state),
    .loadSteps(loadSteps),
    .stepEn(stepEn),
    .done(done)
  );

  stepCounter counter0 (
    .clk(clk),
    .rst(rst),
    .load(start),
    .loadValue(loadSteps),
    .step(stepEn),
    .lastStep(lastStep)
  );

  radix2Core #(.DATA_W(DATA_W)) core0 (
    .clk(clk),
    .rst(rst),
    .start(start),
    .op(op),
    .a(a),
    .b(b),
    .stepEn(stepEn),
    .result(coreResult),
    .rem(coreRem)
  );

  // tags ride along with the operation
  always_ff @(posedge clk) begin
    if (start) begin
      regNoReg <= regNo;
      idReg <= instId;
    end
  end

  assign free = (state == rootDivPkg::ST_IDLE);

  assign res.done = done;
  assign res.result = coreResult;   // frozen once the run ends
  assign res.rem = coreRem;
  assign res.regNo = regNoReg;
  assign res.instId = idReg;

  resultHeld: assert property (@(posedge clk) disable iff (rst)
    res.done && !res.accept |=> res.done && $stable(res.result) && $stable(res.rem)
      && $stable(res.regNo) && $stable(res.instId));

endmodule

// ==== hw/stepCounter.sv ====
module stepCounter (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  rootDivPkg::stepCnt_t loadValue,
  input  logic step,
  output logic lastStep
);

  rootDivPkg::stepCnt_t count;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (load) begin
      count <= loadValue;
    end else if (step) begin
      count <= count - 1'b1;
    end
  end

  // high during the final step of the run
  assign lastStep = (count == rootDivPkg::stepCnt_t'(1));

endmodule

// ==== hw/unitResultIf.sv ====
// one engine's finished result on its way to the arbiter
interface unitResultIf #(
  parameter int DATA_W = 32
);

  logic done;                       // payload valid, held until accept
  logic [DATA_W-1:0] result;        // quotient or root
  logic [DATA_W-1:0] rem;
  rootDivPkg::regNo_t regNo;
  rootDivPkg::instrId_t instId;
  logic accept;                     // from the arbiter, transfer on done && accept

  // engine side
  modport source (
    output done,
    output result,
    output rem,
    output regNo,
    output instId,
    input  accept
  );

  // arbiter side
  modport sink (
    input  done,
    input  result,
    input  rem,
    input  regNo,
    input  instId,
    output accept
  );

endinterface

// ==== rootDiv.f ====
hw/rootDivPkg.sv
hw/unitResultIf.sv
hw/opQueue.sv
hw/iterCtrl.sv
hw/stepCounter.sv
hw/radix2Core.sv
hw/rootDivUnit.sv
hw/resultArbiter.sv
hw/rootDivTop.sv
tests/rootDivChecker.sv
tests/rootDivTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the simulation, then decide pass or fail from the log
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module rootDivTb -f rootDiv.f \
  --Mdir obj_dir -o rootDivSim
./obj_dir/rootDivSim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed" sim.log; then
  exit 0
fi
exit 1

// ==== tests/rootDivChecker.sv ====
// watches both handshakes of the DUT and compares every returned result
module rootDivChecker #(
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  logic inReady,
  input  rootDivPkg::opKind_t inOp,
  input  logic [DATA_W-1:0] inA,
  input  logic [DATA_W-1:0] inB,
  input  rootDivPkg::regNo_t inRegNo,
  input  rootDivPkg::instrId_t inId,
  input  logic outValid,
  input  logic outReady,
  input  logic [DATA_W-1:0] outResult,
  input  logic [DATA_W-1:0] outRem,
  input  rootDivPkg::regNo_t outRegNo,
  input  rootDivPkg::instrId_t outId,
  output int errCount,
  output int pending,
  output int reorderCount
);

  localparam int ID_SPACE = 1024;   // every instrId_t value

  logic [DATA_W-1:0] expRes [ID_SPACE];
  logic [DATA_W-1:0] expRem [ID_SPACE];
  rootDivPkg::regNo_t expReg [ID_SPACE];
  bit inFlight [ID_SPACE];
  int seqOf [ID_SPACE];   // input order of each id
  int inSeq;
  int maxSeqOut;

  // output seen on the last stalled cycle
  bit stalled;
  logic [DATA_W-1:0] heldResult;
  logic [DATA_W-1:0] heldRem;
  rootDivPkg::regNo_t heldReg;
  rootDivPkg::instrId_t heldId;

  // expected {result, rem} straight from the arithmetic definition
  function automatic logic [2*DATA_W-1:0] refCalc(rootDivPkg::opKind_t op,
                                                  logic [DATA_W-1:0] a,
                                                  logic [DATA_W-1:0] b);
    logic [DATA_W-1:0] q;
    logic [DATA_W-1:0] r;
    logic [DATA_W-1:0] lo;
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] mid;
    logic [2*DATA_W-1:0] sq;
    if (op == rootDivPkg::OP_DIV) begin
      if (b == '0) begin
        q = '1;
        r = a;
      end else begin
        q = a / b;
        r = a % b;
      end
    end else begin
      // binary search for the largest root whose square fits in a
      lo = '0;
      hi = DATA_W'({(DATA_W/2){1'b1}});
      while (lo < hi) begin
        mid = lo + ((hi - lo + 1'b1) >> 1);
        sq = {{DATA_W{1'b0}}, mid} * {{DATA_W{1'b0}}, mid};
        if (sq <= {{DATA_W{1'b0}}, a}) begin
          lo = mid;
        end else begin
          hi = mid - 1'b1;
        end
      end
      q = lo;
      r = a - lo * lo;
    end
    return {q, r};
  endfunction

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      errCount++;
    end
  endtask

  // negedge sampling, everything is settled half a cycle after the edge
  always @(negedge clk) begin : sampleCycle
    logic [2*DATA_W-1:0] expected;
    if (rst) begin
      stalled = 1'b0;
      pending = 0;
      inSeq = 0;
      maxSeqOut = -1;
    end else begin
      if (stalled) begin
        if (!outValid) begin
          $display("at %0t outValid dropped while outReady was low", $time);
          errCount++;
        end else begin
          checkValue("outResult", 64'(outResult), 64'(heldResult));
          checkValue("outRem", 64'(outRem), 64'(heldRem));
          checkValue("outRegNo", 64'(outRegNo), 64'(heldReg));
          checkValue("outId", 64'(outId), 64'(heldId));
        end
      end
      stalled = outValid && !outReady;
      heldResult = outResult;
      heldRem = outRem;
      heldReg = outRegNo;
      heldId = outId;

      if (inValid && inReady) begin
        if (inFlight[inId]) begin
          $display("at %0t id %0d was accepted again while still in flight", $time, inId);
          errCount++;
        end
        expected = refCalc(inOp, inA, inB);
        expRes[inId] = expected[2*DATA_W-1:DATA_W];
        expRem[inId] = expected[DATA_W-1:0];
        expReg[inId] = inRegNo;
        inFlight[inId] = 1'b1;
        seqOf[inId] = inSeq;
        inSeq++;
        pending++;
      end

      if (outValid && outReady) begin
        if (!inFlight[outId]) begin
          $display("at %0t a result came back with id %0d, which is not in flight",
                   $time, outId);
          errCount++;
        end else begin
          checkValue("outResult", 64'(outResult), 64'(expRes[outId]));
          checkValue("outRem", 64'(outRem), 64'(expRem[outId]));
          checkValue("outRegNo", 64'(outRegNo), 64'(expReg[outId]));
          inFlight[outId] = 1'b0;
          pending--;
          if (seqOf[outId] < maxSeqOut) begin
            reorderCount++;   // overtook an older operation
          end else begin
            maxSeqOut = seqOf[outId];
          end
        end
      end
    end
  end

endmodule

// ==== tests/rootDivTb.sv ====
module rootDivTb;

  localparam int DATA_W = 32;
  localparam int NUM_UNITS = 4;
  localparam int TOTAL_OPS = 240;      // rough upper bound over all tests
  localparam int STALL_CYCLES = 200;
  localparam int DRAIN_LIMIT = 2000;
  localparam logic [DATA_W-1:0] ONES = '1;
  localparam logic [DATA_W-1:0] TOP_ROOT = DATA_W'({(DATA_W/2){1'b1}});

  logic clk;
  logic rst;
  logic inValid;
  logic inReady;
  rootDivPkg::opKind_t inOp;
  logic [DATA_W-1:0] inA;
  logic [DATA_W-1:0] inB;
  rootDivPkg::regNo_t inRegNo;
  rootDivPkg::instrId_t inId;
  logic outValid;
  logic outReady;
  logic [DATA_W-1:0] outResult;
  logic [DATA_W-1:0] outRem;
  rootDivPkg::regNo_t outRegNo;
  rootDivPkg::instrId_t outId;

  int errCount;
  int pending;
  int reorderCount;
  int localErr;
  int errAtStart;
  int reorderAtStart;
  int testsPassed;
  int testsFailed;
  int nextId;
  bit sawFull;
  logic [31:0] rngState;
  rootDivPkg::opKind_t randOp;

  rootDivTop #(.DATA_W(DATA_W), .NUM_UNITS(NUM_UNITS)) dut0 (
    .clk(clk), .rst(rst),
    .inValid(inValid), .inReady(inReady), .inOp(inOp), .inA(inA), .inB(inB),
    .inRegNo(inRegNo), .inId(inId),
    .outValid(outValid), .outReady(outReady), .outResult(outResult), .outRem(outRem),
    .outRegNo(outRegNo), .outId(outId)
  );

  rootDivChecker #(.DATA_W(DATA_W)) checker0 (
    .clk(clk), .rst(rst),
    .inValid(inValid), .inReady(inReady), .inOp(inOp), .inA(inA), .inB(inB),
    .inRegNo(inRegNo), .inId(inId),
    .outValid(outValid), .outReady(outReady), .outResult(outResult), .outRem(outRem),
    .outRegNo(outRegNo), .outId(outId),
    .errCount(errCount), .pending(pending), .reorderCount(reorderCount)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic logic [DATA_W-1:0] randData();
    logic [63:0] w;
    w = {xorshift(), xorshift()};
    return w[DATA_W-1:0];
  endfunction

  // entered and left one time unit after a rising edge, inValid stays high
  task automatic sendOp(input rootDivPkg::opKind_t op, input logic [DATA_W-1:0] a,
                        input logic [DATA_W-1:0] b);
    bit taken;
    inValid = 1'b1;
    inOp = op;
    inA = a;
    inB = b;
    inRegNo = rootDivPkg::regNo_t'(nextId * 5 + 3);
    inId = rootDivPkg::instrId_t'(nextId);
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = inReady;   // transfer happens on the coming edge
      @(posedge clk);
      #1;
    end
    nextId++;
  endtask

  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (pending != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (pending != 0) begin
      $display("%0d results still outstanding after %0d cycles", pending, DRAIN_LIMIT);
      localErr++;
    end
  endtask

  task automatic beginTest();
    errAtStart = errCount + localErr;
  endtask

  task automatic endTest(input string name);
    int errs;
    waitDrain();
    errs = errCount + localErr - errAtStart;
    if (errs == 0) begin
      testsPassed++;
      $display("test %s: pass", name);
    end else begin
      testsFailed++;
      $display("test %s: FAIL with %0d errors", name, errs);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    inValid = 1'b0;
    inOp = rootDivPkg::OP_DIV;
    inA = '0;
    inB = '0;
    inRegNo = '0;
    inId = '0;
    outReady = 1'b1;
    nextId = 0;
    localErr = 0;
    rngState = 32'd21890;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    beginTest();
    @(negedge clk);
    if (outValid !== 1'b0) begin
      $display("error at %0t: outValid is %b, expected 0", $time, outValid);
      localErr++;
    end
    if (inReady !== 1'b1) begin
      $display("error at %0t: inReady is %b, expected 1", $time, inReady);
      localErr++;
    end
    @(posedge clk);
    #1;
    endTest("reset state");

    beginTest();
    sendOp(rootDivPkg::OP_DIV, 0, 5);
    sendOp(rootDivPkg::OP_DIV, 3, 10);        // divisor above dividend
    sendOp(rootDivPkg::OP_DIV, 12345, 1);
    sendOp(rootDivPkg::OP_DIV, ONES, ONES);
    sendOp(rootDivPkg::OP_DIV, ONES, 1);
    sendOp(rootDivPkg::OP_DIV, ONES, 7);
    sendOp(rootDivPkg::OP_DIV, 100, 0);       // divide by zero
    sendOp(rootDivPkg::OP_DIV, 0, 0);
    inValid = 1'b0;
    endTest("directed division");

    beginTest();
    sendOp(rootDivPkg::OP_ROOT, 0, 0);
    sendOp(rootDivPkg::OP_ROOT, 1, 0);
    sendOp(rootDivPkg::OP_ROOT, 4, 0);
    sendOp(rootDivPkg::OP_ROOT, 99, 0);
    sendOp(rootDivPkg::OP_ROOT, 100, 0);
    sendOp(rootDivPkg::OP_ROOT, 143, ONES);   // b must not matter
    sendOp(rootDivPkg::OP_ROOT, TOP_ROOT * TOP_ROOT, 0);
    sendOp(rootDivPkg::OP_ROOT, TOP_ROOT * TOP_ROOT - 1'b1, 0);
    sendOp(rootDivPkg::OP_ROOT, ONES, 0);
    inValid = 1'b0;
    endTest("directed root");

    beginTest();
    repeat (200) begin
      randOp = xorshift() % 2 == 0 ? rootDivPkg::OP_DIV : rootDivPkg::OP_ROOT;
      if (xorshift() % 16 == 0) begin
        sendOp(randOp, randData(), '0);
      end else begin
        sendOp(randOp, randData(), randData() >> (xorshift() % DATA_W));
      end
    end
    inValid = 1'b0;
    endTest("random stream");

    // division first so the following roots overtake it
    beginTest();
    reorderAtStart = reorderCount;
    for (int i = 0; i < 8; i++) begin
      randOp = i % 2 == 0 ? rootDivPkg::OP_DIV : rootDivPkg::OP_ROOT;
      sendOp(randOp, randData(), randData() >> 8);
    end
    inValid = 1'b0;
    waitDrain();
    if (reorderCount == reorderAtStart) begin
      $display("no result came back out of order during the burst");
      localErr++;
    end
    endTest("parallel burst");

    beginTest();
    sawFull = 1'b0;
    outReady = 1'b0;
    fork
      begin
        // engine 0 divides, so it finishes after the root on engine 1 is waiting
        for (int i = 0; i < 10; i++) begin
          randOp = i % 3 == 1 ? rootDivPkg::OP_ROOT : rootDivPkg::OP_DIV;
          sendOp(randOp, randData(), randData() >> 4);
        end
        inValid = 1'b0;
      end
      begin
        repeat (STALL_CYCLES) begin
          @(negedge clk);
          if (!inReady) sawFull = 1'b1;
        end
        @(posedge clk);
        #1;
        outReady = 1'b1;
      end
    join
    if (!sawFull) begin
      $display("inReady never fell while outReady was held low");
      localErr++;
    end
    endTest("back-pressure");

    $display("tests passed: %0d, tests failed: %0d", testsPassed, testsFailed);
    if (testsFailed == 0 && errCount + localErr == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // serial worst case for every operation plus the stall, with margin
  initial begin : watchdog
    longint limit;
    limit = longint'(TOTAL_OPS) * longint'(int'(rootDivPkg::stepsFor(rootDivPkg::OP_DIV, DATA_W))
            + 10) * 8 + longint'(STALL_CYCLES) * 8 + 10000;
    #(limit);
    $display("timeout, the run did not finish within %0d time units", limit);
    $display("Some tests failed");
    $finish;
  end

endmodule
